// ==== source/board_init_pkg.sv ====
package board_init_pkg;

	// start-up and link supervision states
	typedef enum logic [2:0] {
		ST_INIT,		// hold everything in reset, request phy write
		ST_PHY_SETUP,	// wait for phy write, check assigned ip
		ST_LINK_WAIT,	// poll phy status until link up, full duplex
		ST_SETTLE,		// let the network settle before dhcp
		ST_DHCP_WAIT,	// wait for ack, nak or time out
		ST_RUN,			// ip valid, tx released
		ST_MONITOR		// keep polling the link
	} startup_state_t;

	// arp / ping reply sequencing
	typedef enum logic [1:0] {
		RP_IDLE,
		RP_ARP,
		RP_PING
	} reply_state_t;

	typedef logic [47:0] mac_addr_t;
	typedef logic [31:0] ip_addr_t;
	typedef logic [15:0] phy_reg_t;
	typedef logic [24:0] timer_count_t;

	//--------------------------------------------------
	// phy status register bits
	localparam int unsigned LINK_BIT   = 0;
	localparam int unsigned SPEED_BIT  = 1;
	localparam int unsigned DUPLEX_BIT = 2;

	localparam int unsigned DHCP_MAX_RETRIES = 3;	// retries after the first attempt

	// 169.254.x.x link-local range
	localparam logic [15:0] APIPA_PREFIX = {8'd169, 8'd254};
	localparam ip_addr_t IP_NONE      = 32'h0000_0000;	// 0.0.0.0
	localparam ip_addr_t IP_BROADCAST = 32'hFFFF_FFFF;	// 255.255.255.255

	localparam timer_count_t SETTLE_CYCLES_DEFAULT = 25'd12_500_000;	// one second at 12.5 MHz
	localparam timer_count_t REPLY_TIMEOUT_DEFAULT = 25'd100_000;

endpackage

// ==== source/ip_ctrl_if.sv ====
`timescale 1ns/1ps

// address selection control between start-up fsm and ip selector
interface ip_ctrl_if;

	logic init;				// one-cycle clear of the assigned-valid flag
	logic check_assigned;	// level, evaluate assigned ip while high
	logic use_apipa;		// dhcp gave up, fall back to link-local
	logic assigned_ok;		// assigned ip passed the check

	// sequencer side
	modport ctrl (
		output init,
		output check_assigned,
		output use_apipa,
		input  assigned_ok
	);

	// selector side
	modport sel (
		input  init,
		input  check_assigned,
		input  use_apipa,
		output assigned_ok
	);

endinterface

// ==== source/cycle_timer.sv ====
`timescale 1ns/1ps

module cycle_timer #(
	parameter board_init_pkg::timer_count_t CYCLES = board_init_pkg::SETTLE_CYCLES_DEFAULT
) (
	input  logic PHY_RX_CLOCK,
	input  logic reset_i,
	input  logic run_i,		// count while high, clear while low
	output logic expired_o	// high once CYCLES reached
);

	board_init_pkg::timer_count_t count_q;
	board_init_pkg::timer_count_t count_nxt;

	assign count_nxt = count_q + 1'b1;

	always_ff @(posedge PHY_RX_CLOCK) begin
		if (reset_i || !run_i) begin
			count_q   <= '0;	// idle timer sits at zero
			expired_o <= 1'b0;
		end else if (count_q != CYCLES) begin
			count_q   <= count_nxt;
			expired_o <= (count_nxt == CYCLES);	// flag on the reaching edge
		end else begin
			expired_o <= 1'b1;	// saturated, hold
		end
	end

endmodule

// ==== source/startup_fsm.sv ====
`timescale 1ns/1ps

module startup_fsm (
	input  logic                      PHY_RX_CLOCK,
	input  logic                      reset_i,
	input  logic                      phy_write_done_i,
	input  logic                      phy_read_done_i,
	input  logic                      dhcp_ack_i,
	input  logic                      dhcp_nak_i,
	input  logic                      dhcp_time_out_i,
	input  logic                      settle_expired_i,
	input  board_init_pkg::phy_reg_t  phy_reg_data_i,
	ip_ctrl_if.ctrl                   ctrl,
	output logic                      phy_write_o,
	output logic                      phy_read_o,
	output logic                      dhcp_start_o,
	output logic                      settle_run_o,
	output logic                      reset_o,
	output logic                      tx_reset_o,
	output logic                      ip_valid_o
);

	board_init_pkg::startup_state_t state_q;
	logic [1:0] retry_cnt_q;	// dhcp retries so far
	logic       use_apipa_q;
	logic       link_full_dup;	// link up at full duplex
	logic       link_ok;		// monitor keeps running

	// status register decode
	assign link_full_dup = phy_reg_data_i[board_init_pkg::LINK_BIT] &&
		phy_reg_data_i[board_init_pkg::DUPLEX_BIT];
	assign link_ok = phy_reg_data_i[board_init_pkg::LINK_BIT] ||
		!phy_reg_data_i[board_init_pkg::SPEED_BIT];

	// address selection controls
	assign ctrl.init           = (state_q == board_init_pkg::ST_INIT);
	assign ctrl.check_assigned = (state_q == board_init_pkg::ST_PHY_SETUP);
	assign ctrl.use_apipa      = use_apipa_q;

	always_ff @(posedge PHY_RX_CLOCK) begin
		if (reset_i) begin
			state_q      <= board_init_pkg::ST_INIT;
			retry_cnt_q  <= '0;
			use_apipa_q  <= 1'b0;
			phy_write_o  <= 1'b0;
			phy_read_o   <= 1'b0;
			dhcp_start_o <= 1'b0;
			settle_run_o <= 1'b0;
			reset_o      <= 1'b1;	// downstream held until link up
			tx_reset_o   <= 1'b1;
			ip_valid_o   <= 1'b0;
		end else begin
			dhcp_start_o <= 1'b0;	// single-cycle pulse by default
			case (state_q)
				//--------------------------------------------------
				board_init_pkg::ST_INIT: begin
					reset_o     <= 1'b1;
					tx_reset_o  <= 1'b1;	// no tx until ip known
					ip_valid_o  <= 1'b0;
					retry_cnt_q <= '0;
					use_apipa_q <= 1'b0;
					phy_read_o  <= 1'b0;
					phy_write_o <= 1'b1;	// ask for phy setup write
					state_q     <= board_init_pkg::ST_PHY_SETUP;
				end
				board_init_pkg::ST_PHY_SETUP: begin
					if (phy_write_done_i) begin
						phy_write_o <= 1'b0;
						phy_read_o  <= 1'b1;	// start polling status
						state_q     <= board_init_pkg::ST_LINK_WAIT;
					end
				end
				// poll until link and full duplex reported
				board_init_pkg::ST_LINK_WAIT: begin
					if (phy_read_done_i && link_full_dup) begin
						phy_read_o <= 1'b0;
						reset_o    <= 1'b0;
						if (ctrl.assigned_ok) begin
							state_q <= board_init_pkg::ST_RUN;	// skip dhcp
						end else begin
							settle_run_o <= 1'b1;
							state_q      <= board_init_pkg::ST_SETTLE;
						end
					end
				end
				//--------------------------------------------------
				board_init_pkg::ST_SETTLE: begin
					if (settle_expired_i) begin
						settle_run_o <= 1'b0;	// timer clears for next retry
						dhcp_start_o <= 1'b1;
						state_q      <= board_init_pkg::ST_DHCP_WAIT;
					end
				end
				board_init_pkg::ST_DHCP_WAIT: begin
					if (dhcp_ack_i) begin
						state_q <= board_init_pkg::ST_RUN;
					end else if (dhcp_nak_i || dhcp_time_out_i) begin
						if (retry_cnt_q == board_init_pkg::DHCP_MAX_RETRIES[1:0]) begin
							use_apipa_q <= 1'b1;	// out of retries
							state_q     <= board_init_pkg::ST_RUN;
						end else begin
							retry_cnt_q  <= retry_cnt_q + 1'b1;
							settle_run_o <= 1'b1;
							state_q      <= board_init_pkg::ST_SETTLE;
						end
					end
				end
				//--------------------------------------------------
				board_init_pkg::ST_RUN: begin
					ip_valid_o <= 1'b1;
					tx_reset_o <= 1'b0;	// release tx path
					phy_read_o <= 1'b1;	// one monitor read
					state_q    <= board_init_pkg::ST_MONITOR;
				end
				board_init_pkg::ST_MONITOR: begin
					if (phy_read_done_i) begin
						phy_read_o <= 1'b0;
						if (link_ok)
							state_q <= board_init_pkg::ST_RUN;
						else
							state_q <= board_init_pkg::ST_INIT;	// link lost, restart
					end
				end
				default: state_q <= board_init_pkg::ST_INIT;
			endcase
		end
	end

endmodule

// ==== source/ip_select.sv ====
`timescale 1ns/1ps

module ip_select (
	input  logic                       PHY_RX_CLOCK,
	input  logic                       reset_i,
	ip_ctrl_if.sel                     sel,
	input  board_init_pkg::mac_addr_t  mac_base_i,
	input  logic                       dip_sel_i,
	input  board_init_pkg::ip_addr_t   assign_ip_i,
	input  board_init_pkg::ip_addr_t   yiaddr_i,
	output board_init_pkg::mac_addr_t  this_mac_o,
	output board_init_pkg::ip_addr_t   this_ip_o
);

	board_init_pkg::mac_addr_t mac_nxt;
	board_init_pkg::ip_addr_t  apipa_ip;
	logic assigned_valid_q;	// assigned ip usable
	logic assigned_usable;

	// dip switch flips mac bit 1 so two boards can share a base
	assign mac_nxt  = {mac_base_i[47:2], ~dip_sel_i, mac_base_i[0]};
	assign apipa_ip = {board_init_pkg::APIPA_PREFIX, mac_nxt[15:0]};	// 169.254.mac

	assign assigned_usable = (assign_ip_i != board_init_pkg::IP_NONE) &&
		(assign_ip_i != board_init_pkg::IP_BROADCAST);

	assign sel.assigned_ok = assigned_valid_q;

	always_ff @(posedge PHY_RX_CLOCK) begin
		if (reset_i || sel.init)
			assigned_valid_q <= 1'b0;
		else if (sel.check_assigned && assigned_usable)
			assigned_valid_q <= 1'b1;	// sticky until next init
	end

	// address registers, priority assigned > apipa > dhcp
	always_ff @(posedge PHY_RX_CLOCK) begin
		this_mac_o <= mac_nxt;
		if (assigned_valid_q)
			this_ip_o <= assign_ip_i;
		else if (sel.use_apipa)
			this_ip_o <= apipa_ip;
		else
			this_ip_o <= yiaddr_i;	// dhcp offer
	end

endmodule

// ==== source/reply_sequencer.sv ====
`timescale 1ns/1ps

module reply_sequencer (
	input  logic PHY_RX_CLOCK,
	input  logic reset_i,
	input  logic arp_request_i,
	input  logic ping_request_i,
	input  logic arp_sent_i,
	input  logic ping_sent_i,
	input  logic timeout_i,		// reply timer expired
	output logic timer_run_o,
	output logic send_arp_o,
	output logic ping_reply_o
);

	board_init_pkg::reply_state_t state_q;

	always_ff @(posedge PHY_RX_CLOCK) begin
		if (reset_i) begin
			state_q      <= board_init_pkg::RP_IDLE;
			timer_run_o  <= 1'b0;
			send_arp_o   <= 1'b0;
			ping_reply_o <= 1'b0;
		end else begin
			case (state_q)
				board_init_pkg::RP_IDLE: begin
					send_arp_o   <= 1'b0;
					ping_reply_o <= 1'b0;
					timer_run_o  <= 1'b0;
					if (arp_request_i)	// arp wins a tie
						state_q <= board_init_pkg::RP_ARP;
					else if (ping_request_i)
						state_q <= board_init_pkg::RP_PING;
				end
				//--------------------------------------------------
				board_init_pkg::RP_ARP: begin
					send_arp_o  <= 1'b1;
					timer_run_o <= 1'b1;
					if (arp_sent_i || timeout_i) begin
						send_arp_o  <= 1'b0;	// drop request on the same edge
						timer_run_o <= 1'b0;
						state_q     <= board_init_pkg::RP_IDLE;
					end
				end
				board_init_pkg::RP_PING: begin
					ping_reply_o <= 1'b1;
					timer_run_o  <= 1'b1;
					if (ping_sent_i || timeout_i) begin
						ping_reply_o <= 1'b0;
						timer_run_o  <= 1'b0;
						state_q      <= board_init_pkg::RP_IDLE;
					end
				end
				default: state_q <= board_init_pkg::RP_IDLE;
			endcase
		end
	end

endmodule

// ==== source/net_startup_top.sv ====
`timescale 1ns/1ps

module net_startup_top #(
	parameter board_init_pkg::timer_count_t SETTLE_CYCLES = board_init_pkg::SETTLE_CYCLES_DEFAULT,
	parameter board_init_pkg::timer_count_t REPLY_TIMEOUT = board_init_pkg::REPLY_TIMEOUT_DEFAULT
) (
	input  logic                       PHY_RX_CLOCK,
	input  logic                       reset_i,
	// phy management results
	input  logic                       phy_write_done_i,
	input  logic                       phy_read_done_i,
	input  board_init_pkg::phy_reg_t   phy_reg_data_i,
	// dhcp results
	input  logic                       dhcp_ack_i,
	input  logic                       dhcp_nak_i,
	input  logic                       dhcp_time_out_i,
	input  board_init_pkg::ip_addr_t   yiaddr_i,
	// addressing
	input  board_init_pkg::ip_addr_t   assign_ip_i,
	input  board_init_pkg::mac_addr_t  mac_base_i,
	input  logic [1:0]                 dipsw_i,	// bit 1 selects mac
	// rx requests and tx sent strobes
	input  logic                       arp_request_i,
	input  logic                       ping_request_i,
	input  logic                       arp_sent_i,
	input  logic                       ping_sent_i,
	output logic                       phy_write_o,
	output logic                       phy_read_o,
	output logic                       dhcp_start_o,
	output logic                       reset_o,
	output logic                       tx_reset_o,
	output logic                       ip_valid_o,
	output board_init_pkg::ip_addr_t   this_ip_o,
	output board_init_pkg::mac_addr_t  this_mac_o,
	output logic                       send_arp_o,
	output logic                       ping_reply_o
);

	logic settle_run, settle_expired;	// settle delay handshake
	logic reply_run, reply_timeout;		// reply watchdog

	ip_ctrl_if u_ip_ctrl ();

	//--------------------------------------------------
	startup_fsm u_startup_fsm (
		.PHY_RX_CLOCK     (PHY_RX_CLOCK),
		.reset_i          (reset_i),
		.phy_write_done_i (phy_write_done_i),
		.phy_read_done_i  (phy_read_done_i),
		.dhcp_ack_i       (dhcp_ack_i),
		.dhcp_nak_i       (dhcp_nak_i),
		.dhcp_time_out_i  (dhcp_time_out_i),
		.settle_expired_i (settle_expired),
		.phy_reg_data_i   (phy_reg_data_i),
		.ctrl             (u_ip_ctrl.ctrl),
		.phy_write_o      (phy_write_o),
		.phy_read_o       (phy_read_o),
		.dhcp_start_o     (dhcp_start_o),
		.settle_run_o     (settle_run),
		.reset_o          (reset_o),
		.tx_reset_o       (tx_reset_o),
		.ip_valid_o       (ip_valid_o)
	);

	cycle_timer #(.CYCLES(SETTLE_CYCLES)) u_settle_timer (
		.PHY_RX_CLOCK (PHY_RX_CLOCK),
		.reset_i      (reset_i),
		.run_i        (settle_run),
		.expired_o    (settle_expired)
	);

	ip_select u_ip_select (
		.PHY_RX_CLOCK (PHY_RX_CLOCK),
		.reset_i      (reset_i),
		.sel          (u_ip_ctrl.sel),
		.mac_base_i   (mac_base_i),
		.dip_sel_i    (dipsw_i[1]),
		.assign_ip_i  (assign_ip_i),
		.yiaddr_i     (yiaddr_i),
		.this_mac_o   (this_mac_o),
		.this_ip_o    (this_ip_o)
	);

	//--------------------------------------------------
	reply_sequencer u_reply_sequencer (
		.PHY_RX_CLOCK   (PHY_RX_CLOCK),
		.reset_i        (reset_i),
		.arp_request_i  (arp_request_i),
		.ping_request_i (ping_request_i),
		.arp_sent_i     (arp_sent_i),
		.ping_sent_i    (ping_sent_i),
		.timeout_i      (reply_timeout),
		.timer_run_o    (reply_run),
		.send_arp_o     (send_arp_o),
		.ping_reply_o   (ping_reply_o)
	);

	cycle_timer #(.CYCLES(REPLY_TIMEOUT)) u_reply_timer (
		.PHY_RX_CLOCK (PHY_RX_CLOCK),
		.reset_i      (reset_i),
		.run_i        (reply_run),
		.expired_o    (reply_timeout)
	);

endmodule

// ==== verif/net_startup_checker.sv ====
`timescale 1ns/1ps

module net_startup_checker (
	input logic PHY_RX_CLOCK,
	input logic reset_i,
	input logic phy_write_o,
	input logic phy_read_o,
	input logic send_arp_o,
	input logic ping_reply_o,
	input logic ip_valid_o,
	input logic reset_o,
	input logic tx_reset_o
);

	// one mdio transaction at a time
	phy_req_onehot: assert property (@(posedge PHY_RX_CLOCK) disable iff (reset_i)
		!(phy_write_o && phy_read_o))
		else $error("phy write and phy read requested in the same cycle");

	// tx mac serves one reply type at a time
	reply_onehot: assert property (@(posedge PHY_RX_CLOCK) disable iff (reset_i)
		!(send_arp_o && ping_reply_o))
		else $error("arp send and ping reply requested in the same cycle");

	// a valid address means the board is out of reset
	ip_valid_released: assert property (@(posedge PHY_RX_CLOCK) disable iff (reset_i)
		ip_valid_o |-> (!reset_o && !tx_reset_o))
		else $error("ip valid while reset or tx reset still high");

endmodule

bind net_startup_top net_startup_checker u_checker (
	.PHY_RX_CLOCK (PHY_RX_CLOCK),
	.reset_i      (reset_i),
	.phy_write_o  (phy_write_o),
	.phy_read_o   (phy_read_o),
	.send_arp_o   (send_arp_o),
	.ping_reply_o (ping_reply_o),
	.ip_valid_o   (ip_valid_o),
	.reset_o      (reset_o),
	.tx_reset_o   (tx_reset_o)
);

// ==== verif/tb_net_startup.sv ====
`timescale 1ns/1ps

module tb_net_startup;

	localparam int SETTLE  = 20;	// short settle delay for simulation
	localparam int TIMEOUT = 30;	// reply timeout in cycles
	//--------------------------------------------------
	// watchdog budget is the worst case per test plus a margin
	localparam int STARTUP_CYCLES  = 60 + 4 * (SETTLE + 15);	// polls and four dhcp rounds
	localparam int REPLY_CYCLES    = TIMEOUT + 20;
	localparam int NUM_STARTUPS    = 6;
	localparam int NUM_REPLIES     = 24;
	localparam int WATCHDOG_CYCLES = NUM_STARTUPS * STARTUP_CYCLES +
		NUM_REPLIES * REPLY_CYCLES + 200;

	logic PHY_RX_CLOCK;
	logic reset_i;
	logic phy_write_done_i;
	logic phy_read_done_i;
	logic dhcp_ack_i;
	logic dhcp_nak_i;
	logic dhcp_time_out_i;
	logic [1:0] dipsw_i;
	logic arp_request_i;
	logic ping_request_i;
	logic arp_sent_i;
	logic ping_sent_i;
	board_init_pkg::phy_reg_t phy_reg_data_i;
	board_init_pkg::ip_addr_t yiaddr_i;
	board_init_pkg::ip_addr_t assign_ip_i;
	board_init_pkg::mac_addr_t mac_base_i;
	logic phy_write_o;
	logic phy_read_o;
	logic dhcp_start_o;
	logic reset_o;
	logic tx_reset_o;
	logic ip_valid_o;
	logic send_arp_o;
	logic ping_reply_o;
	board_init_pkg::ip_addr_t this_ip_o;
	board_init_pkg::mac_addr_t this_mac_o;

	integer seed;
	int errors = 0;
	int dhcp_starts = 0;	// running count of dhcp start pulses
	int starts_before;
	int naks;
	int rep;
	string test_name;

	net_startup_top #(
		.SETTLE_CYCLES (25'(SETTLE)),
		.REPLY_TIMEOUT (25'(TIMEOUT))
	) dut (
		.PHY_RX_CLOCK     (PHY_RX_CLOCK),
		.reset_i          (reset_i),
		.phy_write_done_i (phy_write_done_i),
		.phy_read_done_i  (phy_read_done_i),
		.phy_reg_data_i   (phy_reg_data_i),
		.dhcp_ack_i       (dhcp_ack_i),
		.dhcp_nak_i       (dhcp_nak_i),
		.dhcp_time_out_i  (dhcp_time_out_i),
		.yiaddr_i         (yiaddr_i),
		.assign_ip_i      (assign_ip_i),
		.mac_base_i       (mac_base_i),
		.dipsw_i          (dipsw_i),
		.arp_request_i    (arp_request_i),
		.ping_request_i   (ping_request_i),
		.arp_sent_i       (arp_sent_i),
		.ping_sent_i      (ping_sent_i),
		.phy_write_o      (phy_write_o),
		.phy_read_o       (phy_read_o),
		.dhcp_start_o     (dhcp_start_o),
		.reset_o          (reset_o),
		.tx_reset_o       (tx_reset_o),
		.ip_valid_o       (ip_valid_o),
		.this_ip_o        (this_ip_o),
		.this_mac_o       (this_mac_o),
		.send_arp_o       (send_arp_o),
		.ping_reply_o     (ping_reply_o)
	);

	always #5 PHY_RX_CLOCK = ~PHY_RX_CLOCK;	// 10 ns period

	always @(negedge PHY_RX_CLOCK)
		if (dhcp_start_o)
			dhcp_starts++;	// sampled mid-cycle, pulse is one cycle wide

	function automatic int rand_below(input int n);
		int r;
		r = $random(seed);
		return (r & 32'h7fff_ffff) % n;
	endfunction

	// reference rules for the board addresses
	function automatic board_init_pkg::mac_addr_t expected_mac(
		input board_init_pkg::mac_addr_t base, input logic dip);
		board_init_pkg::mac_addr_t m;
		m    = base;
		m[1] = ~dip;	// bit 1 is the inverted switch
		return m;
	endfunction

	function automatic board_init_pkg::ip_addr_t expected_apipa(
		input board_init_pkg::mac_addr_t mac);
		return {8'd169, 8'd254, mac[15:0]};
	endfunction

	task report_mismatch(input string what, input logic [47:0] exp_val,
		input logic [47:0] act_val);
		$display("[FAIL] %s %s: expected %0h actual %0h",
			test_name, what, exp_val, act_val);
		errors++;
	endtask

	task apply_reset;
		@(posedge PHY_RX_CLOCK);
		reset_i <= 1'b1;
		repeat (2) @(posedge PHY_RX_CLOCK);
		reset_i <= 1'b0;
	endtask

	// kind 0 all zeros, 1 all ones, else a usable random address
	task new_addresses(input int assign_kind);
		logic [31:0] r_hi;
		logic [31:0] r_lo;
		logic [31:0] r_ip;
		r_hi = $random(seed);
		r_lo = $random(seed);
		r_ip = $random(seed);
		if (r_ip == 32'h0000_0000 || r_ip == 32'hffff_ffff)
			r_ip = 32'h0a00_0001;
		@(posedge PHY_RX_CLOCK);
		mac_base_i <= {r_hi[15:0], r_lo};
		dipsw_i    <= r_hi[17:16];
		yiaddr_i   <= $random(seed);
		case (assign_kind)
			0:       assign_ip_i <= 32'h0000_0000;
			1:       assign_ip_i <= 32'hffff_ffff;
			default: assign_ip_i <= r_ip;
		endcase
	endtask

	// answer the next phy status read after a random delay
	task phy_read_reply(input board_init_pkg::phy_reg_t value);
		int d;
		do @(negedge PHY_RX_CLOCK); while (!phy_read_o);
		d = rand_below(6);
		repeat (d) @(posedge PHY_RX_CLOCK);
		@(posedge PHY_RX_CLOCK);
		phy_reg_data_i  <= value;
		phy_read_done_i <= 1'b1;
		@(posedge PHY_RX_CLOCK);
		phy_read_done_i <= 1'b0;
	endtask

	task dhcp_reply(input int outcome);	// 0 ack, 1 nak, 2 time out
		int d;
		do @(negedge PHY_RX_CLOCK); while (!dhcp_start_o);
		d = rand_below(8);
		repeat (d) @(posedge PHY_RX_CLOCK);
		@(posedge PHY_RX_CLOCK);
		dhcp_ack_i      <= (outcome == 0);
		dhcp_nak_i      <= (outcome == 1);
		dhcp_time_out_i <= (outcome == 2);
		@(posedge PHY_RX_CLOCK);
		dhcp_ack_i      <= 1'b0;
		dhcp_nak_i      <= 1'b0;
		dhcp_time_out_i <= 1'b0;
	endtask

	//--------------------------------------------------
	// phy write, link polling, dhcp rounds, then wait for ip valid
	task run_startup(input int fails, input logic give_ack);
		int d;
		int i;
		int bad_reads;
		board_init_pkg::phy_reg_t v;
		do @(negedge PHY_RX_CLOCK); while (!phy_write_o);
		d = rand_below(5);
		repeat (d) @(posedge PHY_RX_CLOCK);
		@(posedge PHY_RX_CLOCK);
		phy_write_done_i <= 1'b1;
		@(posedge PHY_RX_CLOCK);
		phy_write_done_i <= 1'b0;
		bad_reads = rand_below(4);
		for (i = 0; i < bad_reads; i++) begin
			v = 16'($random(seed));
			if (v[0] && v[2])
				v[2] = 1'b0;	// link up but half duplex, keep polling
			phy_read_reply(v);
		end
		phy_read_reply(16'($random(seed)) | 16'h0005);	// link and full duplex
		for (i = 0; i < fails; i++)
			dhcp_reply(1 + rand_below(2));
		if (give_ack)
			dhcp_reply(0);
		do @(negedge PHY_RX_CLOCK); while (!ip_valid_o);
		@(negedge PHY_RX_CLOCK);	// address registers one cycle behind
	endtask

	task run_replies(input int count);
		int n;
		int kind;
		int d;
		int held;
		logic want_arp;
		logic answer;
		for (n = 0; n < count; n++) begin
			kind     = rand_below(5);	// arp, ping, both, arp unanswered, ping unanswered
			want_arp = (kind == 0 || kind == 2 || kind == 3);
			answer   = (kind < 3);
			@(posedge PHY_RX_CLOCK);
			arp_request_i  <= want_arp;
			ping_request_i <= (kind == 1 || kind == 2 || kind == 4);
			@(posedge PHY_RX_CLOCK);
			arp_request_i  <= 1'b0;
			ping_request_i <= 1'b0;
			if (want_arp)
				do @(negedge PHY_RX_CLOCK); while (!send_arp_o);
			else
				do @(negedge PHY_RX_CLOCK); while (!ping_reply_o);
			if ((want_arp ? ping_reply_o : send_arp_o) !== 1'b0)
				report_mismatch("other reply output", 0, 1);
			if (answer) begin
				d = rand_below(TIMEOUT - 10);	// sent well before the timeout
				repeat (d) begin
					@(negedge PHY_RX_CLOCK);
					if ((want_arp ? send_arp_o : ping_reply_o) !== 1'b1)
						report_mismatch("held before sent", 1, 0);
				end
				@(posedge PHY_RX_CLOCK);
				arp_sent_i  <= want_arp;
				ping_sent_i <= !want_arp;
				@(posedge PHY_RX_CLOCK);
				arp_sent_i  <= 1'b0;
				ping_sent_i <= 1'b0;
				held = 0;	// request may take up to two cycles to drop
				do begin
					@(negedge PHY_RX_CLOCK);
					held++;
				end while ((send_arp_o || ping_reply_o) && held < 2);
				if (send_arp_o !== 1'b0 || ping_reply_o !== 1'b0)
					report_mismatch("low after sent", 0, {send_arp_o, ping_reply_o});
			end else begin
				held = 0;
				do begin
					@(negedge PHY_RX_CLOCK);
					held++;
				end while (want_arp ? send_arp_o : ping_reply_o);
				if (held < TIMEOUT || held > TIMEOUT + 2)
					report_mismatch("cycles held until timeout", TIMEOUT + 1, held);
			end
			repeat (2) @(posedge PHY_RX_CLOCK);	// back to idle
		end
	endtask

	initial begin
		seed             = 32'h2073_5bef;
		PHY_RX_CLOCK     = 1'b0;
		reset_i          = 1'b1;
		phy_write_done_i = 1'b0;
		phy_read_done_i  = 1'b0;
		phy_reg_data_i   = '0;
		dhcp_ack_i       = 1'b0;
		dhcp_nak_i       = 1'b0;
		dhcp_time_out_i  = 1'b0;
		yiaddr_i         = '0;
		assign_ip_i      = '0;
		mac_base_i       = '0;
		dipsw_i          = '0;
		arp_request_i    = 1'b0;
		ping_request_i   = 1'b0;
		arp_sent_i       = 1'b0;
		ping_sent_i      = 1'b0;

		//--------------------------------------------------
		test_name = "reset_state";
		new_addresses(2);
		apply_reset;
		@(negedge PHY_RX_CLOCK);	// last reset cycle
		if (reset_o !== 1'b1) report_mismatch("reset_o", 1, reset_o);
		if (tx_reset_o !== 1'b1) report_mismatch("tx_reset_o", 1, tx_reset_o);
		if (ip_valid_o !== 1'b0) report_mismatch("ip_valid_o", 0, ip_valid_o);
		if (dhcp_start_o !== 1'b0) report_mismatch("dhcp_start_o", 0, dhcp_start_o);
		if (phy_read_o !== 1'b0) report_mismatch("phy_read_o", 0, phy_read_o);
		if (send_arp_o !== 1'b0) report_mismatch("send_arp_o", 0, send_arp_o);
		if (ping_reply_o !== 1'b0) report_mismatch("ping_reply_o", 0, ping_reply_o);
		if (phy_write_o !== 1'b0) report_mismatch("phy_write_o in reset", 0, phy_write_o);
		@(negedge PHY_RX_CLOCK);
		if (phy_write_o !== 1'b1) report_mismatch("phy_write_o after release", 1, phy_write_o);

		test_name     = "assigned_ip";	// continues from the reset above
		starts_before = dhcp_starts;
		run_startup(0, 1'b0);
		if (this_ip_o !== assign_ip_i) report_mismatch("this_ip_o", assign_ip_i, this_ip_o);
		if (this_mac_o !== expected_mac(mac_base_i, dipsw_i[1]))
			report_mismatch("this_mac_o", expected_mac(mac_base_i, dipsw_i[1]), this_mac_o);
		if (dhcp_starts != starts_before)
			report_mismatch("dhcp starts", 0, dhcp_starts - starts_before);
		if (tx_reset_o !== 1'b0) report_mismatch("tx_reset_o", 0, tx_reset_o);

		//--------------------------------------------------
		test_name = "dhcp_ack";
		for (rep = 0; rep < 2; rep++) begin
			naks = rand_below(4);
			new_addresses(0);
			apply_reset;
			starts_before = dhcp_starts;
			run_startup(naks, 1'b1);
			if (this_ip_o !== yiaddr_i) report_mismatch("this_ip_o", yiaddr_i, this_ip_o);
			if (dhcp_starts - starts_before != naks + 1)
				report_mismatch("dhcp starts", naks + 1, dhcp_starts - starts_before);
		end

		test_name = "dhcp_exhausted";	// broadcast assigned ip is rejected too
		new_addresses(1);
		apply_reset;
		starts_before = dhcp_starts;
		run_startup(4, 1'b0);
		if (this_mac_o !== expected_mac(mac_base_i, dipsw_i[1]))
			report_mismatch("this_mac_o", expected_mac(mac_base_i, dipsw_i[1]), this_mac_o);
		if (this_ip_o !== expected_apipa(expected_mac(mac_base_i, dipsw_i[1])))
			report_mismatch("this_ip_o", expected_apipa(expected_mac(mac_base_i, dipsw_i[1])),
				this_ip_o);
		if (dhcp_starts - starts_before != 4)
			report_mismatch("dhcp starts", 4, dhcp_starts - starts_before);

		//--------------------------------------------------
		test_name = "link_lost";
		new_addresses(2);
		apply_reset;
		run_startup(0, 1'b0);
		phy_read_reply(16'($random(seed)) | 16'h0001);	// link still up
		do @(negedge PHY_RX_CLOCK); while (!phy_read_o);
		if (ip_valid_o !== 1'b1) report_mismatch("ip_valid_o link up", 1, ip_valid_o);
		phy_read_reply((16'($random(seed)) & 16'hfffe) | 16'h0002);	// link down at speed
		do @(negedge PHY_RX_CLOCK); while (!reset_o);
		if (ip_valid_o !== 1'b0) report_mismatch("ip_valid_o link lost", 0, ip_valid_o);
		if (tx_reset_o !== 1'b1) report_mismatch("tx_reset_o link lost", 1, tx_reset_o);
		run_startup(0, 1'b0);	// second start-up
		if (this_ip_o !== assign_ip_i)
			report_mismatch("this_ip_o restart", assign_ip_i, this_ip_o);

		test_name = "replies";
		run_replies(NUM_REPLIES);

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * 10);
		$display("watchdog expired, a test waited too long for the DUT");
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== vlog.f ====
source/board_init_pkg.sv
source/ip_ctrl_if.sv
source/cycle_timer.sv
source/startup_fsm.sv
source/ip_select.sv
source/reply_sequencer.sv
source/net_startup_top.sv
verif/net_startup_checker.sv
verif/tb_net_startup.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	--top-module tb_net_startup --Mdir obj_dir -f vlog.f

./obj_dir/Vtb_net_startup | tee sim.log

if grep -qx "RESULT: PASS" sim.log; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi
